// File: src/vector_pkg.sv
package vector_pkg;

    // beam coordinates span the full 8-bit range
    localparam int COORD_W   = 8;
    localparam int CMD_COUNT = 12;
    localparam int ADDR_W    = 4;

    // bresenham error term, two guard bits keep it signed
    localparam int ERR_W = COORD_W + 2;

    typedef enum logic [1:0] {
        OP_NOP  = 2'd0,
        OP_MOVE = 2'd1,
        OP_LINE = 2'd2,
        OP_END  = 2'd3
    } vec_op_e;

    typedef struct packed {
        vec_op_e              op;
        logic [COORD_W-1:0]   x;
        logic [COORD_W-1:0]   y;
    } vec_cmd_t;

    typedef struct packed {
        logic [COORD_W-1:0]   start_x;
        logic [COORD_W-1:0]   start_y;
        logic [COORD_W-1:0]   end_x;
        logic [COORD_W-1:0]   end_y;
    } segment_t;

    typedef struct packed {
        logic [COORD_W-1:0]   x;
        logic [COORD_W-1:0]   y;
    } pixel_t;

    // drawing list, each line starts where the previous command left the beam
    localparam vec_cmd_t CMD_LIST [CMD_COUNT] = '{
        '{op: OP_MOVE, x: 8'd40,  y: 8'd40},
        '{op: OP_LINE, x: 8'd250, y: 8'd60},
        '{op: OP_LINE, x: 8'd255, y: 8'd90},
        '{op: OP_LINE, x: 8'd235, y: 8'd130},
        '{op: OP_LINE, x: 8'd190, y: 8'd150},
        '{op: OP_NOP,  x: 8'd0,   y: 8'd0},
        '{op: OP_LINE, x: 8'd0,   y: 8'd110},
        '{op: OP_LINE, x: 8'd5,   y: 8'd80},
        '{op: OP_LINE, x: 8'd5,   y: 8'd20},
        '{op: OP_LINE, x: 8'd60,  y: 8'd20},
        '{op: OP_LINE, x: 8'd60,  y: 8'd20},
        '{op: OP_END,  x: 8'd0,   y: 8'd0}
    };

endpackage

// File: src/vector_cmd_rom.sv
`timescale 1ns/10ps

module vector_cmd_rom
    import vector_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // address control from the sequencer
    input  logic     i_inc,
    input  logic     i_zero,

    output vec_cmd_t o_cmd
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(CMD_COUNT - 1);

    logic [ADDR_W-1:0] addr;
    logic              at_last;

    // stop on the last entry so the end command stays visible
    assign at_last = (addr == LAST_ADDR);

    always_ff @(posedge clk) begin
        if (rst || i_zero) begin
            // zero has priority over inc
            addr <= '0;
        end else if (i_inc && !at_last) begin
            addr <= addr + 1'b1;
        end
    end

    // read is combinational from the address register
    assign o_cmd = CMD_LIST[addr];

endmodule

// File: src/draw_vector_master.sv
`timescale 1ns/10ps

module draw_vector_master
    import vector_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // drawer status and run mode
    input  logic     i_busy,
    input  logic     i_loop,

    // command from the rom
    input  vec_cmd_t i_cmd,

    // rom address control
    output logic     o_inc,
    output logic     o_zero,

    // segment to the line drawer
    output logic     o_go,
    output segment_t o_seg,

    output logic     o_done
);

    typedef enum logic [1:0] {
        SEQ_FETCH = 2'd0,
        SEQ_ISSUE = 2'd1,
        SEQ_STOP  = 2'd2
    } seq_state_e;

    seq_state_e         state;
    seq_state_e         state_nxt;
    logic               delay;
    logic               prime;
    logic               prime_nxt;
    logic               run;
    logic               inc_nxt;
    logic               zero_nxt;
    logic               go_nxt;
    segment_t           seg_nxt;
    logic [COORD_W-1:0] prev_x;
    logic [COORD_W-1:0] prev_y;
    logic [COORD_W-1:0] prev_x_nxt;
    logic [COORD_W-1:0] prev_y_nxt;

    // issue phase of the fetch/issue rhythm
    assign delay = (state == SEQ_ISSUE);

    // hold while drawing, and also in the go cycle since busy only rises after it
    assign run = !i_busy && !o_go;

    assign o_done = (state == SEQ_STOP);

    always_comb begin
        state_nxt  = state;
        prime_nxt  = prime;
        inc_nxt    = 1'b0;
        zero_nxt   = 1'b0;
        go_nxt     = 1'b0;
        seg_nxt    = o_seg;
        prev_x_nxt = prev_x;
        prev_y_nxt = prev_y;

        if (run && state != SEQ_STOP) begin
            if (!delay) begin
                // fetch, no increment for the dummy phase after a zero
                inc_nxt   = !prime;
                state_nxt = SEQ_ISSUE;
            end else begin
                state_nxt = SEQ_FETCH;
                if (prime) begin
                    // first issue after a zero only lets the cleared address settle
                    prime_nxt = 1'b0;
                end else begin
                    case (i_cmd.op)
                        OP_MOVE: begin
                            // zero-length segment plots a single dot
                            go_nxt        = 1'b1;
                            seg_nxt       = '{start_x: i_cmd.x, start_y: i_cmd.y,
                                              end_x:   i_cmd.x, end_y:   i_cmd.y};
                            prev_x_nxt    = i_cmd.x;
                            prev_y_nxt    = i_cmd.y;
                        end
                        OP_LINE: begin
                            go_nxt        = 1'b1;
                            seg_nxt       = '{start_x: prev_x,  start_y: prev_y,
                                              end_x:   i_cmd.x, end_y:   i_cmd.y};
                            prev_x_nxt    = i_cmd.x;
                            prev_y_nxt    = i_cmd.y;
                        end
                        OP_END: begin
                            if (i_loop) begin
                                // replay from the top with the beam back at the origin
                                zero_nxt   = 1'b1;
                                prime_nxt  = 1'b1;
                                prev_x_nxt = '0;
                                prev_y_nxt = '0;
                            end else begin
                                state_nxt  = SEQ_STOP;
                            end
                        end
                        default: begin
                            // nop, nothing to draw
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= SEQ_FETCH;
            prime  <= 1'b1;
            // clear the rom address once after reset
            o_zero <= 1'b1;
            o_inc  <= 1'b0;
            o_go   <= 1'b0;
            o_seg  <= '0;
            prev_x <= '0;
            prev_y <= '0;
        end else begin
            state  <= state_nxt;
            prime  <= prime_nxt;
            o_zero <= zero_nxt;
            o_inc  <= inc_nxt;
            o_go   <= go_nxt;
            o_seg  <= seg_nxt;
            prev_x <= prev_x_nxt;
            prev_y <= prev_y_nxt;
        end
    end

endmodule

// File: src/line_draw.sv
`timescale 1ns/10ps

module line_draw
    import vector_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // segment request
    input  logic     i_go,
    input  segment_t i_seg,

    output logic     o_busy,

    // pixel stream, one per cycle while drawing
    output pixel_t   o_pixel,
    output logic     o_pixel_valid
);

    typedef enum logic {
        LD_IDLE = 1'b0,
        LD_DRAW = 1'b1
    } ld_state_e;

    ld_state_e                 state;
    logic [COORD_W-1:0]        cur_x;
    logic [COORD_W-1:0]        cur_y;
    logic [COORD_W-1:0]        end_x;
    logic [COORD_W-1:0]        end_y;
    logic [COORD_W-1:0]        dx;
    logic [COORD_W-1:0]        dy;
    logic                      x_up;
    logic                      y_up;
    logic signed [ERR_W-1:0]   err;

    logic [COORD_W-1:0]        go_dx;
    logic [COORD_W-1:0]        go_dy;
    logic                      go_x_up;
    logic                      go_y_up;
    logic                      at_end;
    logic                      step_x;
    logic                      step_y;
    logic signed [ERR_W:0]     e2;
    logic signed [ERR_W:0]     dx_w;
    logic signed [ERR_W:0]     dy_w;
    logic signed [ERR_W-1:0]   err_nxt;

    // absolute deltas and directions of the incoming segment
    assign go_x_up = (i_seg.end_x >= i_seg.start_x);
    assign go_y_up = (i_seg.end_y >= i_seg.start_y);
    assign go_dx   = go_x_up ? (i_seg.end_x - i_seg.start_x) : (i_seg.start_x - i_seg.end_x);
    assign go_dy   = go_y_up ? (i_seg.end_y - i_seg.start_y) : (i_seg.start_y - i_seg.end_y);

    assign at_end = (cur_x == end_x) && (cur_y == end_y);

    // compare twice the error against the deltas
    assign e2     = {err, 1'b0};
    assign dx_w   = {3'b000, dx};
    assign dy_w   = {3'b000, dy};
    assign step_x = (e2 >= -dy_w);
    assign step_y = (e2 <= dx_w);

    always_comb begin
        err_nxt = err;
        if (step_x) begin
            err_nxt = err_nxt - $signed({2'b00, dy});
        end
        if (step_y) begin
            err_nxt = err_nxt + $signed({2'b00, dx});
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (i_go) begin
                        state <= LD_DRAW;
                    end
                end
                default: begin
                    // endpoint is on the output this cycle
                    if (at_end) begin
                        state <= LD_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LD_IDLE) begin
            if (i_go) begin
                cur_x <= i_seg.start_x;
                cur_y <= i_seg.start_y;
                end_x <= i_seg.end_x;
                end_y <= i_seg.end_y;
                dx    <= go_dx;
                dy    <= go_dy;
                x_up  <= go_x_up;
                y_up  <= go_y_up;
                err   <= $signed({2'b00, go_dx}) - $signed({2'b00, go_dy});
            end
        end else if (!at_end) begin
            err <= err_nxt;
            if (step_x) begin
                cur_x <= x_up ? cur_x + 1'b1 : cur_x - 1'b1;
            end
            if (step_y) begin
                cur_y <= y_up ? cur_y + 1'b1 : cur_y - 1'b1;
            end
        end
    end

    assign o_busy        = (state == LD_DRAW);
    assign o_pixel_valid = (state == LD_DRAW);
    assign o_pixel       = '{x: cur_x, y: cur_y};

endmodule

// File: src/vector_display_top.sv
`timescale 1ns/10ps

module vector_display_top
    import vector_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   i_loop,

    output pixel_t o_pixel,
    output logic   o_pixel_valid,
    output logic   o_done
);

    vec_cmd_t cmd;
    logic     inc;
    logic     zero;
    logic     go;
    logic     busy;
    segment_t seg;

    // command list source
    vector_cmd_rom u_rom (
        .clk    (clk),
        .rst    (rst),
        .i_inc  (inc),
        .i_zero (zero),
        .o_cmd  (cmd)
    );

    draw_vector_master u_master (
        .clk    (clk),
        .rst    (rst),
        .i_busy (busy),
        .i_loop (i_loop),
        .i_cmd  (cmd),
        .o_inc  (inc),
        .o_zero (zero),
        .o_go   (go),
        .o_seg  (seg),
        .o_done (o_done)
    );

    // rasterizer, drives the pixel stream
    line_draw u_line (
        .clk           (clk),
        .rst           (rst),
        .i_go          (go),
        .i_seg         (seg),
        .o_busy        (busy),
        .o_pixel       (o_pixel),
        .o_pixel_valid (o_pixel_valid)
    );

endmodule

// File: tests/tb_vector_display.sv
`timescale 1ns/10ps

module tb_vector_display
    import vector_pkg::*;
();

    // expected pixel with its segment boundary marks
    typedef struct packed {
        logic   first;
        logic   last;
        pixel_t pix;
    } exp_pix_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     i_loop;
    pixel_t   o_pixel;
    logic     o_pixel_valid;
    logic     o_done;

    exp_pix_t exp_q[$];
    exp_pix_t cur_exp;
    pixel_t   prev_pix;
    logic     prev_valid;
    logic     last_was_end;
    logic     loop_dropped;
    logic     done_seen;
    int       pass_len;
    int       pix_count;
    int       cycle_count;
    int       cycle_limit;
    int       drop_delay;
    int       seed;
    int       step_dx;
    int       step_dy;

    vector_display_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .i_loop        (i_loop),
        .o_pixel       (o_pixel),
        .o_pixel_valid (o_pixel_valid),
        .o_done        (o_done)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // endpoint-inclusive bresenham walk from (sx, sy) to (ex, ey)
    task automatic add_segment(input int sx, input int sy, input int ex, input int ey);
        int       x;
        int       y;
        int       dx;
        int       dy;
        int       stx;
        int       sty;
        int       err;
        int       e2;
        logic     first;
        exp_pix_t e;
        x     = sx;
        y     = sy;
        dx    = (ex >= sx) ? ex - sx : sx - ex;
        dy    = (ey >= sy) ? ey - sy : sy - ey;
        stx   = (ex >= sx) ? 1 : -1;
        sty   = (ey >= sy) ? 1 : -1;
        err   = dx - dy;
        first = 1'b1;
        while (1) begin
            e.first = first;
            e.last  = (x == ex) && (y == ey);
            e.pix.x = COORD_W'(x);
            e.pix.y = COORD_W'(y);
            exp_q.push_back(e);
            first = 1'b0;
            if (e.last) break;
            e2 = 2 * err;
            if (e2 >= -dy) begin
                err -= dy;
                x   += stx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sty;
            end
        end
    endtask

    // one pass of the list, the beam starts at the origin each time
    task automatic add_pass();
        int px;
        int py;
        px = 0;
        py = 0;
        for (int i = 0; i < CMD_COUNT; i++) begin
            if (CMD_LIST[i].op == OP_END) break;
            if (CMD_LIST[i].op == OP_MOVE) begin
                add_segment(CMD_LIST[i].x, CMD_LIST[i].y, CMD_LIST[i].x, CMD_LIST[i].y);
            end else if (CMD_LIST[i].op == OP_LINE) begin
                add_segment(px, py, CMD_LIST[i].x, CMD_LIST[i].y);
            end
            if (CMD_LIST[i].op == OP_MOVE || CMD_LIST[i].op == OP_LINE) begin
                px = CMD_LIST[i].x;
                py = CMD_LIST[i].y;
            end
        end
    endtask

    // timeout guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_failure("timeout: pixel stream or done did not finish in time");
        end
    end

    // outputs are sampled on the falling edge where they are stable
    always @(negedge clk) begin
        if (rst) begin
            assert (!o_pixel_valid && !o_done)
                else report_failure("pixel valid or done raised during reset");
        end else begin
            if (o_pixel_valid) begin
                assert (exp_q.size() > 0)
                    else report_failure("pixel seen after the expected stream ended");
                cur_exp = exp_q.pop_front();
                step_dx = int'(o_pixel.x) - int'(prev_pix.x);
                step_dy = int'(o_pixel.y) - int'(prev_pix.y);
                assert (!prev_valid || (step_dx * step_dx <= 1 && step_dy * step_dy <= 1))
                    else report_failure("pixel moved more than one step inside a segment");
                assert (o_pixel.x == cur_exp.pix.x)
                    else report_failure($sformatf("mismatch o_pixel.x expected %h actual %h",
                                                  cur_exp.pix.x, o_pixel.x));
                assert (o_pixel.y == cur_exp.pix.y)
                    else report_failure($sformatf("mismatch o_pixel.y expected %h actual %h",
                                                  cur_exp.pix.y, o_pixel.y));
                assert (cur_exp.first == !prev_valid)
                    else report_failure("segment does not begin at its start point");
                last_was_end = cur_exp.last;
                pix_count    = pix_count + 1;
            end else if (prev_valid) begin
                assert (last_was_end)
                    else report_failure("segment stopped before its end point");
            end
            assert (!o_done || loop_dropped)
                else report_failure("o_done rose while i_loop was high");
            assert (!o_done || exp_q.size() == 0)
                else report_failure("o_done rose before the last pass was drawn");
            assert (o_done || !done_seen)
                else report_failure("o_done fell after the sequencer stopped");
            done_seen = done_seen || o_done;
        end
        prev_valid = o_pixel_valid;
        prev_pix   = o_pixel;
    end

    initial begin
        rst          = 1'b1;
        i_loop       = 1'b1;
        seed         = 24926;
        prev_valid   = 1'b0;
        prev_pix     = '0;
        last_was_end = 1'b0;
        loop_dropped = 1'b0;
        done_seen    = 1'b0;
        pix_count    = 0;
        cycle_count  = 0;
        add_pass();
        pass_len = exp_q.size();
        add_pass();
        add_pass();
        cycle_limit = 4 * (pass_len + 3 * CMD_COUNT) * 3 + 100;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // two looped passes, then drop the loop somewhere inside the third
        while (pix_count < 2 * pass_len + 1) @(posedge clk);
        drop_delay = $unsigned($random(seed)) % (pass_len - 1);
        repeat (drop_delay) @(posedge clk);
        i_loop       <= 1'b0;
        loop_dropped = 1'b1;

        while (!o_done) @(posedge clk);
        // no pixel may follow once the sequencer has stopped
        repeat (200) @(posedge clk);

        if (exp_q.size() != 0) begin
            report_failure("expected pixels were never drawn");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: list.f
src/vector_pkg.sv
src/vector_cmd_rom.sv
src/draw_vector_master.sv
src/line_draw.sv
src/vector_display_top.sv
tests/tb_vector_display.sv

// File: Bender.yml
package:
  name: vector_display

sources:
  - files:
      - src/vector_pkg.sv
      - src/vector_cmd_rom.sv
      - src/draw_vector_master.sv
      - src/line_draw.sv
      - src/vector_display_top.sv
  - target: test
    files:
      - tests/tb_vector_display.sv
